//--- include/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Bank geometry.
`define CACHE_NUM_SETS 8
`define CACHE_NUM_WAYS 4
`define CACHE_BLOCK_SIZE 4

// Datapath widths.
`define CACHE_WORD_W 32
`define CACHE_ADDR_W 32

`endif

//--- logic/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

  typedef logic [`CACHE_WORD_W-1:0] word_t;
  typedef logic [$clog2(`CACHE_NUM_SETS)-1:0] set_idx_t;
  typedef logic [$clog2(`CACHE_NUM_WAYS)-1:0] way_idx_t;
  typedef logic [$clog2(`CACHE_BLOCK_SIZE)-1:0] blk_off_t;
  typedef logic [`CACHE_ADDR_W-$bits(set_idx_t)-$bits(blk_off_t)-1:0] tag_t;

  // One age per way, so ages run 0 to NUM_WAYS-1.
  typedef logic [$clog2(`CACHE_NUM_WAYS)-1:0] age_t;

  typedef struct packed {
    tag_t     tag;
    set_idx_t set_idx;
    blk_off_t blk_off;
  } word_addr_t;

  // rw is 1 for a store.
  typedef struct packed {
    logic       rw;
    word_addr_t addr;
    word_t      store_value;
  } cache_req_t;

  typedef struct packed {
    logic                             valid;
    logic                             dirty;
    tag_t                             tag;
    word_t [`CACHE_BLOCK_SIZE-1:0]    block;
  } cache_frame_t;

  typedef struct packed {
    age_t [`CACHE_NUM_WAYS-1:0] age;
    way_idx_t                   lru_way;
  } lru_frame_t;

  typedef struct packed {
    cache_req_t req;
    set_idx_t   victim_set;
    way_idx_t   victim_way;
  } mshr_t;

  typedef enum logic [2:0] {
    IDLE,
    VICTIM_EJECT,
    BLOCK_PULL,
    FINISH,
    REPLAY
  } miss_state_e;

endpackage

//--- logic/cache_request_decoder.sv
`timescale 1ns/1ps

module cache_request_decoder (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  req_valid,
  input  cache_pkg::cache_req_t req,
  input  logic                  ready,
  output logic                  dec_valid,
  output cache_pkg::cache_req_t dec_req
);

  logic accept;

  // Requests are only taken while the miss path is idle.
  assign accept = req_valid && ready;

  always_ff @(posedge CLK) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;
    end
  end

  // Held until the next accepted request, the replay looks it up again.
  always_ff @(posedge CLK) begin
    if (accept) begin
      dec_req.rw          <= req.rw;
      dec_req.addr        <= '{tag: req.addr.tag, set_idx: req.addr.set_idx,
                               blk_off: req.addr.blk_off};
      dec_req.store_value <= req.store_value;
    end
  end

endmodule

//--- logic/cache_bank.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_bank (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     dec_valid,
  input  cache_pkg::cache_req_t    dec_req,
  input  logic                     miss_busy,
  input  logic                     install,
  input  cache_pkg::set_idx_t      fill_set,
  input  cache_pkg::way_idx_t      fill_way,
  input  cache_pkg::cache_frame_t  fill_frame,
  output logic                     hit,
  output cache_pkg::way_idx_t      hit_way,
  output cache_pkg::word_t         hit_word,
  output cache_pkg::cache_frame_t [`CACHE_NUM_SETS-1:0][`CACHE_NUM_WAYS-1:0] bank_state
);

  cache_pkg::set_idx_t req_set;
  logic                fill_done;
  logic                store_hit;

  assign req_set = dec_req.addr.set_idx;

  // Tag compare over every way of the indexed set.
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (bank_state[req_set][w].valid && (bank_state[req_set][w].tag == dec_req.addr.tag)) begin
        hit     = 1'b1;
        hit_way = cache_pkg::way_idx_t'(w);
      end
    end
  end

  assign hit_word = bank_state[req_set][hit_way].block[dec_req.addr.blk_off];

  // The replay cycle follows the install.
  always_ff @(posedge CLK) begin
    if (reset) begin
      fill_done <= 1'b0;
    end else begin
      fill_done <= install;
    end
  end

  // New requests store while idle, the replay stores during the miss.
  assign store_hit = hit && dec_req.rw && ((dec_valid && !miss_busy) || fill_done);

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
          bank_state[s][w].valid <= 1'b0;
          bank_state[s][w].dirty <= 1'b0;
        end
      end
    end else begin
      if (install) begin
        bank_state[fill_set][fill_way] <= fill_frame;
      end
      if (store_hit) begin
        bank_state[req_set][hit_way].block[dec_req.addr.blk_off] <= dec_req.store_value;
        bank_state[req_set][hit_way].dirty                       <= 1'b1;
      end
    end
  end

endmodule

//--- logic/lru_tracker.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module lru_tracker (
  input  logic                      CLK,
  input  logic                      reset,
  input  logic                      touch,
  input  cache_pkg::set_idx_t       touch_set,
  input  cache_pkg::way_idx_t       touch_way,
  input  logic                      reset_age,
  input  cache_pkg::set_idx_t       lookup_set,
  input  logic [`CACHE_NUM_WAYS-1:0] valid_ways,
  output cache_pkg::lru_frame_t [`CACHE_NUM_SETS-1:0] lru_state,
  output cache_pkg::way_idx_t       victim_way
);

  cache_pkg::lru_frame_t cur_frame;
  cache_pkg::lru_frame_t next_frame;
  cache_pkg::age_t       touch_age;

  always_comb begin
    cur_frame = lru_state[touch_set];
    // A way filled from empty counts as the oldest one.
    touch_age  = valid_ways[touch_way] ? cur_frame.age[touch_way] : '1;
    next_frame = cur_frame;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (cache_pkg::way_idx_t'(w) == touch_way) begin
        next_frame.age[w] = '0;
      end else if (cur_frame.age[w] < touch_age) begin
        next_frame.age[w] = cur_frame.age[w] + 1'b1;
      end
    end
    // Oldest way, lowest index on a tie.
    next_frame.lru_way = '0;
    for (int w = 1; w < `CACHE_NUM_WAYS; w++) begin
      if (next_frame.age[w] > next_frame.age[next_frame.lru_way]) begin
        next_frame.lru_way = cache_pkg::way_idx_t'(w);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
        lru_state[s] <= '0;
      end
    end else if (touch || reset_age) begin
      lru_state[touch_set] <= next_frame;
    end
  end

  // Lowest empty way first, else the LRU way.
  always_comb begin
    victim_way = lru_state[lookup_set].lru_way;
    for (int w = `CACHE_NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_ways[w]) begin
        victim_way = cache_pkg::way_idx_t'(w);
      end
    end
  end

endmodule

//--- logic/miss_handler.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module miss_handler (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     dec_valid,
  input  cache_pkg::cache_req_t    dec_req,
  input  logic                     hit,
  input  cache_pkg::way_idx_t      hit_way,
  input  cache_pkg::word_t         hit_word,
  input  cache_pkg::cache_frame_t [`CACHE_NUM_SETS-1:0][`CACHE_NUM_WAYS-1:0] bank_state,
  input  cache_pkg::way_idx_t      victim_way,
  input  logic                     mem_rdata_valid,
  input  cache_pkg::word_t         mem_rdata,
  output logic                     ready,
  output logic                     resp_valid,
  output cache_pkg::word_t         resp_data,
  output logic                     mem_read,
  output cache_pkg::word_addr_t    mem_addr,
  output logic                     mem_write,
  output cache_pkg::word_addr_t    mem_waddr,
  output cache_pkg::word_t         mem_wdata,
  output logic                     install,
  output cache_pkg::set_idx_t      fill_set,
  output cache_pkg::way_idx_t      fill_way,
  output cache_pkg::cache_frame_t  fill_frame,
  output logic                     lru_touch,
  output cache_pkg::set_idx_t      touch_set,
  output cache_pkg::way_idx_t      touch_way,
  output cache_pkg::miss_state_e   miss_state,
  output cache_pkg::mshr_t         mshr,
  output cache_pkg::cache_frame_t  pull_buffer
);

  localparam cache_pkg::blk_off_t LAST_WORD = cache_pkg::blk_off_t'(`CACHE_BLOCK_SIZE - 1);

  cache_pkg::blk_off_t     word_cnt;
  logic                    read_sent;
  logic                    idle_hit;
  logic                    new_miss;
  logic                    replay;
  cache_pkg::cache_frame_t evict_frame;
  cache_pkg::cache_frame_t victim_frame;

  assign ready        = (miss_state == cache_pkg::IDLE);
  assign replay       = (miss_state == cache_pkg::REPLAY);
  assign idle_hit     = ready && dec_valid && hit;
  assign new_miss     = ready && dec_valid && !hit;
  assign evict_frame  = bank_state[dec_req.addr.set_idx][victim_way];
  assign victim_frame = bank_state[mshr.victim_set][mshr.victim_way];

  always_ff @(posedge CLK) begin
    if (reset) begin
      miss_state <= cache_pkg::IDLE;
      word_cnt   <= '0;
      read_sent  <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= idle_hit || replay;
      case (miss_state)
        cache_pkg::IDLE: begin
          word_cnt  <= '0;
          read_sent <= 1'b0;
          if (new_miss) begin
            miss_state <= (evict_frame.valid && evict_frame.dirty) ?
                          cache_pkg::VICTIM_EJECT : cache_pkg::BLOCK_PULL;
          end
        end
        cache_pkg::VICTIM_EJECT: begin
          word_cnt <= (word_cnt == LAST_WORD) ? '0 : word_cnt + 1'b1;
          if (word_cnt == LAST_WORD) begin
            miss_state <= cache_pkg::BLOCK_PULL;
          end
        end
        cache_pkg::BLOCK_PULL: begin
          read_sent <= 1'b1;
          // Gaps between rdata strobes just hold the count.
          if (mem_rdata_valid) begin
            word_cnt <= (word_cnt == LAST_WORD) ? '0 : word_cnt + 1'b1;
            if (word_cnt == LAST_WORD) begin
              miss_state <= cache_pkg::FINISH;
            end
          end
        end
        cache_pkg::FINISH: miss_state <= cache_pkg::REPLAY;
        default: miss_state <= cache_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (new_miss) begin
      mshr              <= '{req: dec_req, victim_set: dec_req.addr.set_idx,
                             victim_way: victim_way};
      pull_buffer.valid <= 1'b0;
      pull_buffer.dirty <= 1'b0;
      pull_buffer.tag   <= dec_req.addr.tag;
    end
    if ((miss_state == cache_pkg::BLOCK_PULL) && mem_rdata_valid) begin
      pull_buffer.block[word_cnt] <= mem_rdata;
      if (word_cnt == LAST_WORD) begin
        pull_buffer.valid <= 1'b1;
      end
    end
    // Stores answer with the value they wrote.
    if (idle_hit) begin
      resp_data <= dec_req.rw ? dec_req.store_value : hit_word;
    end else if (replay) begin
      resp_data <= mshr.req.rw ? mshr.req.store_value : hit_word;
    end
  end

  assign mem_write = (miss_state == cache_pkg::VICTIM_EJECT);
  assign mem_waddr = '{tag: victim_frame.tag, set_idx: mshr.victim_set, blk_off: word_cnt};
  assign mem_wdata = victim_frame.block[word_cnt];

  assign mem_read = (miss_state == cache_pkg::BLOCK_PULL) && !read_sent;
  assign mem_addr = '{tag: mshr.req.addr.tag, set_idx: mshr.victim_set, blk_off: '0};

  // The completed pull is a clean, valid frame with the new tag.
  assign install    = (miss_state == cache_pkg::FINISH);
  assign fill_set   = mshr.victim_set;
  assign fill_way   = mshr.victim_way;
  assign fill_frame = pull_buffer;

  // FINISH ages the victim through install. Hits and the replay touch the hit way.
  assign lru_touch = idle_hit || (replay && hit);
  assign touch_set = ready ? dec_req.addr.set_idx : mshr.victim_set;
  assign touch_way = install ? mshr.victim_way : hit_way;

endmodule

//--- logic/cache_integrity_monitor.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_integrity_monitor (
  input  logic                     CLK,
  input  logic                     reset,
  input  cache_pkg::lru_frame_t [`CACHE_NUM_SETS-1:0] lru_state,
  input  cache_pkg::miss_state_e   miss_state,
  input  cache_pkg::mshr_t         mshr,
  input  cache_pkg::cache_frame_t  pull_buffer,
  input  cache_pkg::cache_frame_t [`CACHE_NUM_SETS-1:0][`CACHE_NUM_WAYS-1:0] bank_state,
  output logic [2:0]               check_flags
);

  logic                    finish_q;
  logic                    lru_err;
  logic                    age_err;
  logic                    repl_err;
  cache_pkg::cache_frame_t victim_frame;
  cache_pkg::age_t         victim_age;

  // The recorded LRU way must hold the largest age in its set.
  always_comb begin
    lru_err = 1'b0;
    for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
      for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
        if (lru_state[s].age[lru_state[s].lru_way] < lru_state[s].age[w]) begin
          lru_err = 1'b1;
        end
      end
    end
  end

  assign victim_frame = bank_state[mshr.victim_set][mshr.victim_way];
  assign victim_age   = lru_state[mshr.victim_set].age[mshr.victim_way];

  // Checked in the cycle after FINISH, before the replay can store.
  assign age_err  = finish_q && (victim_age != '0);
  assign repl_err = finish_q && !(victim_frame.valid &&
                                  (victim_frame.tag == mshr.req.addr.tag) &&
                                  (victim_frame.block == pull_buffer.block));

  always_ff @(posedge CLK) begin
    if (reset) begin
      finish_q    <= 1'b0;
      check_flags <= '0;
    end else begin
      finish_q    <= (miss_state == cache_pkg::FINISH);
      check_flags <= check_flags | {repl_err, age_err, lru_err};
    end
  end

endmodule

//--- logic/cache_top.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_top (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  req_valid,
  input  cache_pkg::cache_req_t req,
  output logic                  ready,
  output logic                  resp_valid,
  output cache_pkg::word_t      resp_data,
  output logic                  mem_read,
  output cache_pkg::word_addr_t mem_addr,
  output logic                  mem_write,
  output cache_pkg::word_addr_t mem_waddr,
  output cache_pkg::word_t      mem_wdata,
  input  logic                  mem_rdata_valid,
  input  cache_pkg::word_t      mem_rdata,
  output logic [2:0]            check_flags
);

  logic                    dec_valid;
  cache_pkg::cache_req_t   dec_req;
  logic                    hit;
  cache_pkg::way_idx_t     hit_way;
  cache_pkg::word_t        hit_word;
  cache_pkg::cache_frame_t [`CACHE_NUM_SETS-1:0][`CACHE_NUM_WAYS-1:0] bank_state;
  cache_pkg::lru_frame_t [`CACHE_NUM_SETS-1:0] lru_state;
  cache_pkg::way_idx_t     victim_way;
  logic [`CACHE_NUM_WAYS-1:0] valid_ways;
  logic                    install;
  cache_pkg::set_idx_t     fill_set;
  cache_pkg::way_idx_t     fill_way;
  cache_pkg::cache_frame_t fill_frame;
  logic                    lru_touch;
  cache_pkg::set_idx_t     touch_set;
  cache_pkg::way_idx_t     touch_way;
  cache_pkg::miss_state_e  miss_state;
  cache_pkg::mshr_t        mshr;
  cache_pkg::cache_frame_t pull_buffer;

  // Valid bits of the requested set for victim choice.
  for (genvar w = 0; w < `CACHE_NUM_WAYS; w++) begin : g_valid_ways
    assign valid_ways[w] = bank_state[dec_req.addr.set_idx][w].valid;
  end

  cache_request_decoder u_decoder (
    .CLK(CLK), .reset(reset), .req_valid(req_valid), .req(req), .ready(ready),
    .dec_valid(dec_valid), .dec_req(dec_req)
  );

  cache_bank u_bank (
    .CLK(CLK), .reset(reset), .dec_valid(dec_valid), .dec_req(dec_req), .miss_busy(~ready),
    .install(install), .fill_set(fill_set), .fill_way(fill_way), .fill_frame(fill_frame),
    .hit(hit), .hit_way(hit_way), .hit_word(hit_word), .bank_state(bank_state)
  );

  lru_tracker u_lru (
    .CLK(CLK), .reset(reset), .touch(lru_touch), .touch_set(touch_set),
    .touch_way(touch_way), .reset_age(install), .lookup_set(dec_req.addr.set_idx),
    .valid_ways(valid_ways), .lru_state(lru_state), .victim_way(victim_way)
  );

  miss_handler u_miss (
    .CLK(CLK), .reset(reset), .dec_valid(dec_valid), .dec_req(dec_req), .hit(hit),
    .hit_way(hit_way), .hit_word(hit_word), .bank_state(bank_state),
    .victim_way(victim_way), .mem_rdata_valid(mem_rdata_valid), .mem_rdata(mem_rdata),
    .ready(ready), .resp_valid(resp_valid), .resp_data(resp_data), .mem_read(mem_read),
    .mem_addr(mem_addr), .mem_write(mem_write), .mem_waddr(mem_waddr),
    .mem_wdata(mem_wdata), .install(install), .fill_set(fill_set), .fill_way(fill_way),
    .fill_frame(fill_frame), .lru_touch(lru_touch), .touch_set(touch_set),
    .touch_way(touch_way), .miss_state(miss_state), .mshr(mshr), .pull_buffer(pull_buffer)
  );

  cache_integrity_monitor u_monitor (
    .CLK(CLK), .reset(reset), .lru_state(lru_state), .miss_state(miss_state),
    .mshr(mshr), .pull_buffer(pull_buffer), .bank_state(bank_state),
    .check_flags(check_flags)
  );

endmodule

//--- tests/cache_tb.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tb;

  localparam int BLOCK_SIZE  = `CACHE_BLOCK_SIZE;
  localparam int HIT_LATENCY = 2;
  // Worst-case miss latency of all tests, summed, times four.
  localparam int TIMEOUT_CYCLES = 2000;
  localparam cache_pkg::word_t FILL_PATTERN = 32'hA5A5A5A5;

  logic                  CLK;
  logic                  reset;
  logic                  req_valid;
  cache_pkg::cache_req_t req;
  logic                  ready;
  logic                  resp_valid;
  cache_pkg::word_t      resp_data;
  logic                  mem_read;
  cache_pkg::word_addr_t mem_addr;
  logic                  mem_write;
  cache_pkg::word_addr_t mem_waddr;
  cache_pkg::word_t      mem_wdata;
  logic                  mem_rdata_valid;
  cache_pkg::word_t      mem_rdata;
  logic [2:0]            check_flags;

  int          error_count;
  int          cycle_count;
  logic [15:0] lfsr_state;

  // Memory contents, later writes win.
  cache_pkg::word_addr_t written_addr[$];
  cache_pkg::word_t      written_data[$];
  cache_pkg::word_addr_t read_log[$];
  cache_pkg::word_addr_t eject_addr[$];
  cache_pkg::word_t      eject_data[$];

  cache_top u_cache_top (
    .CLK(CLK), .reset(reset), .req_valid(req_valid), .req(req), .ready(ready),
    .resp_valid(resp_valid), .resp_data(resp_data), .mem_read(mem_read),
    .mem_addr(mem_addr), .mem_write(mem_write), .mem_waddr(mem_waddr),
    .mem_wdata(mem_wdata), .mem_rdata_valid(mem_rdata_valid), .mem_rdata(mem_rdata),
    .check_flags(check_flags)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  // Taps for x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic next_lfsr_bit();
    logic feedback;
    feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], feedback};
    return feedback;
  endfunction

  function automatic cache_pkg::word_t random_bits(input int count);
    cache_pkg::word_t value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | cache_pkg::word_t'(next_lfsr_bit());
    end
    return value;
  endfunction

  function automatic cache_pkg::word_t fill_word(input cache_pkg::word_addr_t addr);
    return addr ^ FILL_PATTERN;
  endfunction

  function automatic cache_pkg::word_t model_word(input cache_pkg::word_addr_t addr);
    cache_pkg::word_t value;
    value = fill_word(addr);
    for (int i = 0; i < written_addr.size(); i++) begin
      if (written_addr[i] == addr) begin
        value = written_data[i];
      end
    end
    return value;
  endfunction

  function automatic cache_pkg::word_addr_t make_addr(input cache_pkg::tag_t tag,
      input cache_pkg::set_idx_t set_idx, input cache_pkg::blk_off_t blk_off);
    cache_pkg::word_addr_t addr;
    addr.tag     = tag;
    addr.set_idx = set_idx;
    addr.blk_off = blk_off;
    return addr;
  endfunction

  task automatic note_failure(input string what);
    $display("At %0t: %s", $time, what);
    error_count++;
  endtask

  task automatic expect_word(input string name, input cache_pkg::word_t actual,
                             input cache_pkg::word_t expected);
    if (actual !== expected) begin
      $display("Error: %s is %h, expected %h", name, actual, expected);
      error_count++;
    end
  endtask

  task automatic compare_waddr(input string name, input cache_pkg::word_addr_t actual,
                               input cache_pkg::word_addr_t expected);
    if (actual !== expected) begin
      $display("Error: %s is %h, expected %h", name, actual, expected);
      error_count++;
    end
  endtask

  task automatic verify_flags(input logic [2:0] actual, input logic [2:0] expected);
    if (actual !== expected) begin
      $display("Error: check_flags is %h, expected %h", actual, expected);
      error_count++;
    end
  endtask

  // Serves one block pull, with a gap of 1 to 3 cycles before the first word.
  task automatic serve_pull(input cache_pkg::word_addr_t base);
    cache_pkg::word_addr_t addr;
    int                    gap;
    gap = 1 + int'(random_bits(2) % 3);
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      repeat (gap) begin
        @(posedge CLK);
        #2;
        mem_rdata_valid = 1'b0;
      end
      @(posedge CLK);
      #2;
      addr         = make_addr(base.tag, base.set_idx, cache_pkg::blk_off_t'(i));
      mem_rdata    = model_word(addr);
      mem_rdata_valid = 1'b1;
      gap = int'(random_bits(1));
    end
    @(posedge CLK);
    #2;
    mem_rdata_valid = 1'b0;
  endtask

  initial begin
    mem_rdata_valid = 1'b0;
    mem_rdata       = '0;
    forever begin
      @(negedge CLK);
      if (mem_write === 1'b1) begin
        written_addr.push_back(mem_waddr);
        written_data.push_back(mem_wdata);
        eject_addr.push_back(mem_waddr);
        eject_data.push_back(mem_wdata);
      end
      if (mem_read === 1'b1) begin
        read_log.push_back(mem_addr);
        serve_pull(mem_addr);
      end
    end
  end

  task automatic issue_request(input logic rw, input cache_pkg::word_addr_t addr,
                               input cache_pkg::word_t value,
                               output cache_pkg::word_t data, output int latency);
    while (!ready) begin
      @(posedge CLK);
      #2;
    end
    req_valid       = 1'b1;
    req.rw          = rw;
    req.addr        = addr;
    req.store_value = value;
    @(posedge CLK);
    #2;
    req_valid = 1'b0;
    latency   = 1;
    while (resp_valid !== 1'b1) begin
      @(posedge CLK);
      #2;
      latency++;
    end
    data = resp_data;
  endtask

  // Hits answer in two cycles with no block read, misses read exactly one block.
  task automatic check_path(input cache_pkg::word_addr_t addr, input logic exp_hit,
                            input int latency, input int reads_before);
    if (exp_hit && (latency != HIT_LATENCY)) begin
      note_failure($sformatf("Hit at %h answered after %0d cycles", addr, latency));
    end
    if (exp_hit && (read_log.size() != reads_before)) begin
      note_failure($sformatf("Access at %h should hit but read a block", addr));
    end
    if (!exp_hit && (read_log.size() != reads_before + 1)) begin
      note_failure($sformatf("Access at %h should miss and read one block", addr));
    end else if (!exp_hit) begin
      compare_waddr("mem_addr", read_log[$], make_addr(addr.tag, addr.set_idx, '0));
    end
  endtask

  task automatic load_and_check(input cache_pkg::word_addr_t addr,
                                input cache_pkg::word_t expected, input logic exp_hit);
    cache_pkg::word_t data;
    int               latency;
    int               reads_before;
    reads_before = read_log.size();
    issue_request(1'b0, addr, '0, data, latency);
    expect_word("resp_data", data, expected);
    check_path(addr, exp_hit, latency, reads_before);
  endtask

  task automatic store_and_check(input cache_pkg::word_addr_t addr,
                                 input cache_pkg::word_t value, input logic exp_hit);
    cache_pkg::word_t data;
    int               latency;
    int               reads_before;
    reads_before = read_log.size();
    issue_request(1'b1, addr, value, data, latency);
    expect_word("resp_data", data, value);
    check_path(addr, exp_hit, latency, reads_before);
  endtask

  task automatic load_miss_then_hit();
    cache_pkg::word_addr_t first;
    cache_pkg::word_addr_t second;
    first  = make_addr(27'h10, 3'd1, 2'd2);
    second = make_addr(27'h10, 3'd1, 2'd3);
    load_and_check(first, model_word(first), 1'b0);
    load_and_check(second, model_word(second), 1'b1);
  endtask

  task automatic store_miss_merge();
    cache_pkg::word_addr_t addr;
    cache_pkg::word_t      value;
    addr  = make_addr(27'h20, 3'd2, 2'd1);
    value = random_bits(32);
    store_and_check(addr, value, 1'b0);
    load_and_check(addr, value, 1'b1);
  endtask

  task automatic lru_victim_order();
    cache_pkg::word_addr_t blocks [5];
    for (int i = 0; i < 5; i++) begin
      blocks[i] = make_addr(cache_pkg::tag_t'(32'h31 + i), 3'd3, 2'd0);
    end
    for (int i = 0; i < 4; i++) begin
      load_and_check(blocks[i], model_word(blocks[i]), 1'b0);
    end
    // Touching the first block leaves the second as the oldest.
    load_and_check(blocks[0], model_word(blocks[0]), 1'b1);
    load_and_check(blocks[4], model_word(blocks[4]), 1'b0);
    load_and_check(blocks[0], model_word(blocks[0]), 1'b1);
    load_and_check(blocks[2], model_word(blocks[2]), 1'b1);
    load_and_check(blocks[3], model_word(blocks[3]), 1'b1);
    load_and_check(blocks[4], model_word(blocks[4]), 1'b1);
    load_and_check(blocks[1], model_word(blocks[1]), 1'b0);
  endtask

  task automatic dirty_victim_eject();
    cache_pkg::word_addr_t victim;
    cache_pkg::word_addr_t others [4];
    cache_pkg::word_addr_t waddr;
    cache_pkg::word_t      value;
    victim = make_addr(27'h41, 3'd4, 2'd2);
    value  = random_bits(32);
    store_and_check(victim, value, 1'b0);
    for (int i = 0; i < 4; i++) begin
      others[i] = make_addr(cache_pkg::tag_t'(32'h42 + i), 3'd4, 2'd0);
    end
    for (int i = 0; i < 3; i++) begin
      load_and_check(others[i], model_word(others[i]), 1'b0);
    end
    eject_addr.delete();
    eject_data.delete();
    load_and_check(others[3], model_word(others[3]), 1'b0);
    if (eject_addr.size() != BLOCK_SIZE) begin
      note_failure($sformatf("Dirty victim gave %0d write strobes", eject_addr.size()));
    end else begin
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        waddr = make_addr(victim.tag, victim.set_idx, cache_pkg::blk_off_t'(i));
        compare_waddr("mem_waddr", eject_addr[i], waddr);
        expect_word("mem_wdata", eject_data[i], (waddr == victim) ? value : fill_word(waddr));
      end
    end
    load_and_check(victim, value, 1'b0);
  endtask

  initial begin
    reset       = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    error_count = 0;
    lfsr_state  = 16'd39;
    repeat (2) @(posedge CLK);
    #2;
    reset = 1'b0;
    if (ready !== 1'b1) begin
      note_failure("Cache is not ready after reset");
    end
    verify_flags(check_flags, 3'b000);
    load_miss_then_hit();
    verify_flags(check_flags, 3'b000);
    store_miss_merge();
    verify_flags(check_flags, 3'b000);
    lru_victim_order();
    verify_flags(check_flags, 3'b000);
    dirty_victim_eject();
    verify_flags(check_flags, 3'b000);
    $display("Tests done after %0d cycles with %0d errors", cycle_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
logic/cache_pkg.sv
logic/cache_request_decoder.sv
logic/cache_bank.sv
logic/lru_tracker.sv
logic/miss_handler.sv
logic/cache_integrity_monitor.sv
logic/cache_top.sv
tests/cache_tb.sv

//--- Bender.yml
package:
  name: cache_bank

sources:
  - include_dirs:
      - include
    files:
      - logic/cache_pkg.sv
      - logic/cache_request_decoder.sv
      - logic/cache_bank.sv
      - logic/lru_tracker.sv
      - logic/miss_handler.sv
      - logic/cache_integrity_monitor.sv
      - logic/cache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cache_tb.sv
